/* files.f */
logic/prf_pkg.sv
logic/uop_pkg.sv
logic/phys_regfile.sv
logic/reg_read_stage.sv
logic/alu.sv
logic/writeback_unit.sv
logic/exec_cluster.sv
verif/tb_exec_cluster.sv

/* logic/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu import prf_pkg::*, uop_pkg::*; (
    input  uop_bundle_t uops,
    input  prf_rdata_t  rdata,
    input  prf_wb_t     bypass_alu0,
    input  prf_wb_t     bypass_alu1,
    output prf_wb_t     wb_data,
    output fu_done_t    done
);

    logic       byp0_src0, byp1_src0;
    logic       byp0_src1, byp1_src1;
    word_t      src0, src1;
    word_t      logic_res, shift_res, arith_res, count_res, branch_res;
    word_t      src1_eff, sum, result, target;
    logic [4:0] shamt;
    logic       is_sub, overflow, taken;

    // leading run of bit_val from the msb, 0 to 32
    function automatic word_t lead_count(word_t val, logic bit_val);
        word_t n;
        logic  run;
        n   = '0;
        run = 1'b1;
        for (int i = 31; i >= 0; i--) begin
            if (run && val[i] == bit_val) begin
                n = n + 1;
            end else begin
                run = 1'b0;
            end
        end
        return n;
    endfunction

    assign byp0_src0 = uops.op0_re && bypass_alu0.wen && bypass_alu0.rd == uops.op0_preg;
    assign byp1_src0 = uops.op0_re && bypass_alu1.wen && bypass_alu1.rd == uops.op0_preg;
    assign byp0_src1 = uops.op1_re && bypass_alu0.wen && bypass_alu0.rd == uops.op1_preg;
    assign byp1_src1 = uops.op1_re && bypass_alu1.wen && bypass_alu1.rd == uops.op1_preg;

    always_comb begin
        if (byp0_src0) src0 = bypass_alu0.wdata;
        else if (byp1_src0) src0 = bypass_alu1.wdata;
        else src0 = rdata.rs0_data;
    end

    always_comb begin
        if (!uops.op1_re) src1 = uops.imm;
        else if (byp0_src1) src1 = bypass_alu0.wdata;
        else if (byp1_src1) src1 = bypass_alu1.wdata;
        else src1 = rdata.rs1_data;
    end

    always_comb begin
        case (uops.op)
            op_or, op_ori, op_lui: logic_res = src0 | src1;
            op_and, op_andi:       logic_res = src0 & src1;
            op_nor:                logic_res = ~(src0 | src1);
            op_xor, op_xori:       logic_res = src0 ^ src1;
            default:               logic_res = '0;
        endcase
    end

    assign shamt = src1[4:0];

    always_comb begin
        case (uops.op)
            op_sll, op_sllv: shift_res = src0 << shamt;
            op_srl, op_srlv: shift_res = src0 >> shamt;
            op_sra, op_srav: shift_res = word_t'($signed(src0) >>> shamt);
            default:         shift_res = '0;
        endcase
    end

    // subtract as add of inverted operand plus carry in
    assign is_sub   = uops.op inside {op_sub, op_subu};
    assign src1_eff = is_sub ? ~src1 : src1;
    assign sum      = src0 + src1_eff + {31'b0, is_sub};
    assign overflow = (uops.op inside {op_add, op_addi, op_sub}) &&
                      src0[31] == src1_eff[31] && sum[31] != src0[31];

    always_comb begin
        case (uops.op)
            op_slt, op_slti:   arith_res = {31'b0, $signed(src0) < $signed(src1)};
            op_sltu, op_sltiu: arith_res = {31'b0, src0 < src1};
            default:           arith_res = sum;
        endcase
    end

    assign count_res  = (uops.op == op_clz) ? lead_count(src0, 1'b0) : lead_count(src0, 1'b1);
    assign branch_res = uops.pc + 32'd8;    // link address

    always_comb begin
        case (uops.op)
            op_beq:                       taken = src0 == src1;
            op_bne:                       taken = src0 != src1;
            op_bgez, op_bgezal:           taken = !src0[31];
            op_bgtz:                      taken = !src0[31] && src0 != '0;
            op_blez:                      taken = src0[31] || src0 == '0;
            op_bltz, op_bltzal:           taken = src0[31];
            op_j, op_jal, op_jr, op_jalr: taken = 1'b1;
            default:                      taken = 1'b0;
        endcase
    end

    assign target = (uops.op inside {op_jr, op_jalr}) ? src0 : uops.pred_addr;

    always_comb begin
        case (uops.alu_type)
            alu_logic:  result = logic_res;
            alu_shift:  result = shift_res;
            alu_arith:  result = arith_res;
            alu_move:   result = src0;
            alu_count:  result = count_res;
            alu_branch: result = branch_res;
            default:    result = '0;
        endcase
    end

    assign wb_data.wen   = uops.valid && uops.dst_we && !overflow;  // trap, no write
    assign wb_data.rd    = uops.dst_preg;
    assign wb_data.wdata = result;

    assign done.set_finish   = uops.valid;
    assign done.id           = uops.id;
    assign done.set_branch   = uops.valid && uops.branch_type != br_normal;
    assign done.branch_taken = taken;
    assign done.branch_addr  = target;
    assign done.overflow     = overflow;

endmodule

`default_nettype wire

/* logic/exec_cluster.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_cluster import prf_pkg::*, uop_pkg::*; #(
    parameter int NUM_PREGS = 64,
    parameter int ROB_DEPTH = 32
) (
    input  wire         clk,
    input  wire         reset,
    input  uop_bundle_t issue [2],
    input  wire         retire_valid,
    input  rob_id_t     retire_id,
    output prf_wb_t     wb [2],
    output logic        retire_done,
    output logic        retire_taken,
    output word_t       retire_target,
    output logic        retire_overflow
);

    preg_t       raddr [4];
    prf_rdata_t  rdata [2];
    prf_rdata_t  opnd [2];
    uop_bundle_t uops [2];
    prf_wb_t     alu_wb [2];
    fu_done_t    alu_done [2];

    reg_read_stage rr_i (
        .clk   (clk),
        .reset (reset),
        .issue (issue),
        .raddr (raddr),
        .rdata (rdata),
        .uops  (uops),
        .opnd  (opnd)
    );

    phys_regfile #(
        .NUM_PREGS (NUM_PREGS)
    ) prf_i (
        .clk   (clk),
        .reset (reset),
        .raddr (raddr),
        .rdata (rdata),
        .wr    (wb)         // registered writeback drives both write ports
    );

    alu alu0_i (
        .uops        (uops[0]),
        .rdata       (opnd[0]),
        .bypass_alu0 (wb[0]),
        .bypass_alu1 (wb[1]),
        .wb_data     (alu_wb[0]),
        .done        (alu_done[0])
    );

    alu alu1_i (
        .uops        (uops[1]),
        .rdata       (opnd[1]),
        .bypass_alu0 (wb[0]),
        .bypass_alu1 (wb[1]),
        .wb_data     (alu_wb[1]),
        .done        (alu_done[1])
    );

    writeback_unit #(
        .ROB_DEPTH (ROB_DEPTH)
    ) wbu_i (
        .clk             (clk),
        .reset           (reset),
        .wb_in           (alu_wb),
        .done_in         (alu_done),
        .wb              (wb),
        .retire_valid    (retire_valid),
        .retire_id       (retire_id),
        .retire_done     (retire_done),
        .retire_taken    (retire_taken),
        .retire_overflow (retire_overflow),
        .retire_target   (retire_target)
    );

endmodule

`default_nettype wire

/* logic/phys_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module phys_regfile import prf_pkg::*; #(
    parameter int NUM_PREGS = 64
) (
    input  wire        clk,
    input  wire        reset,
    input  preg_t      raddr [4],
    output prf_rdata_t rdata [2],
    input  prf_wb_t    wr [2]
);

    word_t regs [NUM_PREGS];
    word_t rd_word [4];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr[0].wen) regs[wr[0].rd] <= wr[0].wdata;
            if (wr[1].wen) regs[wr[1].rd] <= wr[1].wdata;   // lane 1 last, wins
        end
    end

    // write-through so a same-cycle write is seen by the reader
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rd_word[i] = regs[raddr[i]];
            if (wr[0].wen && wr[0].rd == raddr[i]) rd_word[i] = wr[0].wdata;
            if (wr[1].wen && wr[1].rd == raddr[i]) rd_word[i] = wr[1].wdata;
        end
    end

    assign rdata[0].rs0_data = rd_word[0];
    assign rdata[0].rs1_data = rd_word[1];
    assign rdata[1].rs0_data = rd_word[2];
    assign rdata[1].rs1_data = rd_word[3];

endmodule

`default_nettype wire

/* logic/prf_pkg.sv */
`default_nettype none

package prf_pkg;

    typedef logic [31:0] word_t;
    typedef logic [5:0]  preg_t;

    // one register file write, also used as a bypass source
    typedef struct packed {
        logic  wen;
        preg_t rd;
        word_t wdata;
    } prf_wb_t;

    // both source operands of one lane
    typedef struct packed {
        word_t rs0_data;
        word_t rs1_data;
    } prf_rdata_t;

endpackage

`default_nettype wire

/* logic/reg_read_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_read_stage import prf_pkg::*, uop_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  uop_bundle_t issue [2],
    output preg_t       raddr [4],
    input  prf_rdata_t  rdata [2],
    output uop_bundle_t uops [2],
    output prf_rdata_t  opnd [2]
);

    // ports 0/1 serve lane 0, ports 2/3 lane 1
    assign raddr[0] = issue[0].op0_preg;
    assign raddr[1] = issue[0].op1_preg;
    assign raddr[2] = issue[1].op0_preg;
    assign raddr[3] = issue[1].op1_preg;

    always_ff @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            if (reset) begin
                uops[l].valid <= 1'b0;
            end else begin
                uops[l] <= issue[l];
                opnd[l] <= rdata[l];    // operands travel with their uop
            end
        end
    end

endmodule

`default_nettype wire

/* logic/uop_pkg.sv */
`default_nettype none

package uop_pkg;

    import prf_pkg::*;

    typedef logic [4:0] rob_id_t;

    typedef enum logic [5:0] {
        op_or, op_ori, op_lui, op_and,
        op_andi, op_nor, op_xor, op_xori,
        op_sll, op_sllv, op_srl,
        op_srlv, op_sra, op_srav,
        op_add, op_addi, op_addu,
        op_sub, op_subu,
        op_slt, op_slti, op_sltu, op_sltiu,
        op_mfhi, op_mthi,                   // hi/lo renamed, both just pass operand 0
        op_clz, op_clo,
        op_beq, op_bne,
        op_bgez, op_bgezal, op_bgtz,
        op_blez, op_bltz, op_bltzal,
        op_j, op_jal, op_jr, op_jalr
    } alu_op_e;

    // picks which result group goes to writeback
    typedef enum logic [2:0] {
        alu_logic,
        alu_shift,
        alu_arith,
        alu_move,
        alu_count,
        alu_branch
    } alu_type_e;

    typedef enum logic [1:0] {
        br_normal,
        br_cond,
        br_jump
    } branch_type_e;

    typedef struct packed {
        logic         valid;
        rob_id_t      id;
        alu_op_e      op;
        alu_type_e    alu_type;
        branch_type_e branch_type;
        preg_t        op0_preg;
        logic         op0_re;
        preg_t        op1_preg;
        logic         op1_re;       // low selects imm
        preg_t        dst_preg;
        logic         dst_we;
        word_t        imm;          // lui comes in pre-shifted
        word_t        pc;
        word_t        pred_addr;
    } uop_bundle_t;

    // completion report towards the rob table
    typedef struct packed {
        logic    set_finish;
        rob_id_t id;
        logic    set_branch;
        logic    branch_taken;
        word_t   branch_addr;
        logic    overflow;
    } fu_done_t;

endpackage

`default_nettype wire

/* logic/writeback_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module writeback_unit import prf_pkg::*, uop_pkg::*; #(
    parameter int ROB_DEPTH = 32
) (
    input  wire      clk,
    input  wire      reset,
    input  prf_wb_t  wb_in [2],
    input  fu_done_t done_in [2],
    output prf_wb_t  wb [2],
    input  wire      retire_valid,
    input  rob_id_t  retire_id,
    output logic     retire_done,
    output logic     retire_taken,
    output logic     retire_overflow,
    output word_t    retire_target
);

    typedef struct packed {
        logic  done;
        logic  taken;
        logic  overflow;
        word_t target;
    } cpl_entry_t;

    fu_done_t   done_q [2];
    cpl_entry_t cpl_tbl [ROB_DEPTH];

    always_ff @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            if (reset) begin
                wb[l].wen            <= 1'b0;
                done_q[l].set_finish <= 1'b0;
            end else begin
                wb[l]     <= wb_in[l];
                done_q[l] <= done_in[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                cpl_tbl[i] <= '0;
            end
        end else begin
            if (retire_valid) cpl_tbl[retire_id] <= '0;
            // set after clear so a same-id set wins
            for (int l = 0; l < 2; l++) begin
                if (done_q[l].set_finish) begin
                    cpl_tbl[done_q[l].id].done     <= 1'b1;
                    cpl_tbl[done_q[l].id].overflow <= done_q[l].overflow;
                    cpl_tbl[done_q[l].id].taken    <= done_q[l].set_branch &&
                                                      done_q[l].branch_taken;
                    cpl_tbl[done_q[l].id].target   <= done_q[l].set_branch ?
                                                      done_q[l].branch_addr : '0;
                end
            end
        end
    end

    assign retire_done     = cpl_tbl[retire_id].done;
    assign retire_taken    = cpl_tbl[retire_id].taken;
    assign retire_overflow = cpl_tbl[retire_id].overflow;
    assign retire_target   = cpl_tbl[retire_id].target;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing -f files.f --top-module tb_exec_cluster -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* verif/tb_exec_cluster.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_exec_cluster import prf_pkg::*, uop_pkg::*;;

    localparam int ZERO_CYCLES  = 32;
    localparam int RAND_CYCLES  = 3000;
    localparam int DRAIN_CYCLES = 50;
    localparam int MAX_CYCLES   = 4 + ZERO_CYCLES + RAND_CYCLES + DRAIN_CYCLES + 10;

    logic        clk = 1'b0;
    logic        reset;
    uop_bundle_t issue [2];
    logic        retire_valid;
    rob_id_t     retire_id;
    prf_wb_t     wb [2];
    logic        retire_done, retire_taken, retire_overflow;
    word_t       retire_target;

    word_t   lfsr = 32'd28;
    word_t   mregs [64];                // model registers written right at issue
    prf_wb_t exp_wb [3][2];             // stage 2 is due on wb this cycle
    logic    exp_chk [3][2];
    logic    exp_taken [32];
    logic    exp_ovf [32];
    word_t   exp_target [32];
    rob_id_t free_ids [$];
    rob_id_t rob_q [$];
    int      rob_cyc [$];
    int      iter = 0;
    int      retires = 0;
    int      checks = 0;
    int      errors = 0;
    int      cycles = 0;
    logic    recheck_pend = 1'b0;
    rob_id_t recheck_id;

    exec_cluster dut_i (
        .clk             (clk),
        .reset           (reset),
        .issue           (issue),
        .retire_valid    (retire_valid),
        .retire_id       (retire_id),
        .wb              (wb),
        .retire_done     (retire_done),
        .retire_taken    (retire_taken),
        .retire_target   (retire_target),
        .retire_overflow (retire_overflow)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic word_t lfsr_step(word_t s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t count_lead(word_t v, logic b);
        int n;
        n = 0;
        while (n < 32 && v[31 - n] == b) n++;
        return word_t'(n);
    endfunction

    task automatic check_value(string name, word_t expected, word_t actual);
        checks++;
        if (expected !== actual) begin
            $display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    function automatic uop_bundle_t random_uop(rob_id_t id);
        uop_bundle_t u;
        int          sel;
        word_t       ksel;
        u = '0;
        sel = int'(rand_bits(6)) % 39;
        ksel = rand_bits(3);
        u.op = alu_op_e'(sel[5:0]);
        u.alu_type = sel <= 7 ? alu_logic : sel <= 13 ? alu_shift : sel <= 22 ? alu_arith :
                     sel <= 24 ? alu_move : sel <= 26 ? alu_count : alu_branch;
        u.valid = 1'b1;
        u.id = id;
        u.op0_re = 1'b1;
        u.op1_re = !(u.op inside {op_ori, op_lui, op_andi, op_xori, op_sll, op_srl, op_sra,
                                  op_addi, op_slti, op_sltiu});
        u.op0_preg = preg_t'(rand_bits(4));   // small range forces dependencies
        u.op1_preg = preg_t'(rand_bits(4));
        u.dst_preg = preg_t'(rand_bits(4));
        if (u.alu_type == alu_branch) begin
            u.branch_type = (u.op inside {op_j, op_jal, op_jr, op_jalr}) ? br_jump : br_cond;
            u.dst_we = u.op inside {op_bgezal, op_bltzal, op_jal, op_jalr};
        end else begin
            u.dst_we = rand_bits(3) != 0;
        end
        case (ksel)
            0: u.imm = 32'h0000_0000;
            1: u.imm = 32'hffff_ffff;
            2: u.imm = 32'h7fff_ffff;
            3: u.imm = 32'h8000_0000;
            default: u.imm = rand_bits(32);
        endcase
        u.pc = rand_bits(32) & 32'hffff_fffc;
        u.pred_addr = rand_bits(32) & 32'hffff_fffc;
        return u;
    endfunction

    task automatic model_uop(input uop_bundle_t u, output prf_wb_t w, output logic ovf,
                             output logic tkn, output word_t tgt);
        word_t       a, b, res;
        logic [32:0] wide;
        a = mregs[u.op0_preg];
        b = u.op1_re ? mregs[u.op1_preg] : u.imm;
        ovf = 1'b0;
        tkn = 1'b0;
        tgt = '0;
        case (u.op)
            op_or, op_ori, op_lui: res = a | b;
            op_and, op_andi:       res = a & b;
            op_nor:                res = ~(a | b);
            op_xor, op_xori:       res = a ^ b;
            op_sll, op_sllv:       res = a << b[4:0];
            op_srl, op_srlv:       res = a >> b[4:0];
            op_sra, op_srav:       res = word_t'($signed(a) >>> b[4:0]);
            op_add, op_addi, op_addu: begin
                wide = {a[31], a} + {b[31], b};
                res = wide[31:0];
                ovf = u.op != op_addu && wide[32] != wide[31];
            end
            op_sub, op_subu: begin
                wide = {a[31], a} - {b[31], b};
                res = wide[31:0];
                ovf = u.op == op_sub && wide[32] != wide[31];
            end
            op_slt, op_slti:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sltu, op_sltiu: res = (a < b) ? 32'd1 : 32'd0;
            op_mfhi, op_mthi:  res = a;
            op_clz:            res = count_lead(a, 1'b0);
            op_clo:            res = count_lead(a, 1'b1);
            default: begin
                res = u.pc + 32'd8;     // link value
                case (u.op)
                    op_beq:              tkn = a == b;
                    op_bne:              tkn = a != b;
                    op_bgez, op_bgezal:  tkn = $signed(a) >= 0;
                    op_bgtz:             tkn = $signed(a) > 0;
                    op_blez:             tkn = $signed(a) <= 0;
                    op_bltz, op_bltzal:  tkn = $signed(a) < 0;
                    default:             tkn = 1'b1;
                endcase
                tgt = (u.op == op_jr || u.op == op_jalr) ? a : u.pred_addr;
            end
        endcase
        w.wen = u.valid && u.dst_we && !ovf;
        w.rd = u.dst_preg;
        w.wdata = res;
    endtask

    // mode 0 reads every register after reset, 1 random stream, 2 drain
    task automatic run_cycle(input int mode);
        uop_bundle_t u [2];
        prf_wb_t     w [2];
        logic        ovf, tkn;
        word_t       tgt;
        int          chk_kind;
        rob_id_t     rid;
        logic        ret_tkn, ret_ovf;
        word_t       ret_tgt;
        @(posedge clk);
        chk_kind = 0;
        rid = '0;
        ret_tkn = 1'b0;
        ret_ovf = 1'b0;
        ret_tgt = '0;
        retire_valid <= 1'b0;
        if (mode == 0) begin
            rid = rob_id_t'(iter);
            chk_kind = 2;
        end else if (recheck_pend) begin
            rid = recheck_id;
            chk_kind = 2;                   // cleared by last retire
            recheck_pend = 1'b0;
            free_ids.push_back(rid);
        end else if (rob_q.size() > 0 && iter >= rob_cyc[0] + 3) begin
            rid = rob_q.pop_front();
            void'(rob_cyc.pop_front());
            retire_valid <= 1'b1;
            chk_kind = 1;
            ret_tkn = exp_taken[rid];       // id may be reissued below
            ret_tgt = exp_target[rid];
            ret_ovf = exp_ovf[rid];
            retires++;
            if (retires % 4 == 0) begin
                recheck_pend = 1'b1;
                recheck_id = rid;
            end else begin
                free_ids.push_back(rid);
            end
        end
        retire_id <= rid;
        for (int l = 0; l < 2; l++) begin
            u[l] = '0;
            if (mode == 0) begin
                u[l].op = op_mfhi;
                u[l].alu_type = alu_move;
                u[l].op0_re = 1'b1;
                u[l].op0_preg = preg_t'(2 * iter + l);
            end else if (mode == 1 && free_ids.size() > 0 && rand_bits(2) != 0) begin
                u[l] = random_uop(free_ids.pop_front());
            end
        end
        if (u[0].dst_we && u[1].dst_we && u[0].dst_preg == u[1].dst_preg)
            u[1].dst_preg = {2'b00, u[1].dst_preg[3:0] + 4'd1};
        for (int l = 0; l < 2; l++) begin
            exp_wb[2][l] = exp_wb[1][l];
            exp_chk[2][l] = exp_chk[1][l];
            exp_wb[1][l] = exp_wb[0][l];
            exp_chk[1][l] = exp_chk[0][l];
            model_uop(u[l], w[l], ovf, tkn, tgt);
            exp_wb[0][l] = w[l];
            exp_chk[0][l] = mode == 0 || w[l].wen;
            if (u[l].valid) begin
                exp_taken[u[l].id] = tkn;
                exp_target[u[l].id] = tgt;
                exp_ovf[u[l].id] = ovf;
                rob_q.push_back(u[l].id);
                rob_cyc.push_back(iter);
            end
        end
        for (int l = 0; l < 2; l++) begin
            if (w[l].wen) mregs[w[l].rd] = w[l].wdata;
        end
        issue[0] <= u[0];
        issue[1] <= u[1];
        @(negedge clk);
        for (int l = 0; l < 2; l++) begin
            check_value($sformatf("wb[%0d].wen", l), word_t'(exp_wb[2][l].wen),
                        word_t'(wb[l].wen));
            if (exp_chk[2][l]) begin
                check_value($sformatf("wb[%0d].rd", l), word_t'(exp_wb[2][l].rd),
                            word_t'(wb[l].rd));
                check_value($sformatf("wb[%0d].wdata", l), exp_wb[2][l].wdata, wb[l].wdata);
            end
        end
        if (chk_kind == 2) begin
            check_value("retire_done", 32'd0, word_t'(retire_done));
        end else if (chk_kind == 1) begin
            check_value("retire_done", 32'd1, word_t'(retire_done));
            check_value("retire_taken", word_t'(ret_tkn), word_t'(retire_taken));
            check_value("retire_target", ret_tgt, retire_target);
            check_value("retire_overflow", word_t'(ret_ovf), word_t'(retire_overflow));
        end
        iter++;
    endtask

    initial begin
        reset = 1'b1;
        issue[0] = '0;
        issue[1] = '0;
        retire_valid = 1'b0;
        retire_id = '0;
        for (int i = 0; i < 64; i++) begin
            mregs[i] = '0;
            if (i < 32) free_ids.push_back(rob_id_t'(i));
            if (i < 3) begin
                exp_wb[i][0] = '0;
                exp_wb[i][1] = '0;
                exp_chk[i][0] = 1'b0;
                exp_chk[i][1] = 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        repeat (ZERO_CYCLES) run_cycle(0);
        repeat (RAND_CYCLES) run_cycle(1);
        repeat (DRAIN_CYCLES) run_cycle(2);
        if (rob_q.size() != 0) begin
            $display("%0d completed uops were never retired after the drain", rob_q.size());
            errors++;
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
